/* hw/cache_cfg.svh */
////////////////////////////////////////////////////////////////////////////
// data cache geometry and burst RAM depth
// tag width follows from the RAM byte address minus index, column and
// byte offset bits
////////////////////////////////////////////////////////////////////////////

`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// 2^4 = 16 lines
`define CACHE_LINE_IX_BITS 4

// 2^3 = 8 words of 32 bits per line
`define CACHE_COL_IX_BITS 3

// one line is four 64-bit RAM beats
`define CACHE_BEATS_PER_LINE 4

// burst RAM depth in 64-bit words
`define CACHE_BR_ADDR_BITS 10

// RAM byte address is 3 bits wider than the 64-bit word address
`define CACHE_TAG_BITS (`CACHE_BR_ADDR_BITS + 3 - `CACHE_LINE_IX_BITS - `CACHE_COL_IX_BITS - 2)

`endif

/* hw/cache_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// data cache types
// width typedefs shared by the cache blocks and the burst FSM states
////////////////////////////////////////////////////////////////////////////

`include "cache_cfg.svh"

package cache_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [63:0] beat_t;

  typedef logic [`CACHE_LINE_IX_BITS-1:0] line_ix_t;
  typedef logic [`CACHE_COL_IX_BITS-1:0]  col_ix_t;
  typedef logic [1:0]                     beat_ix_t;
  typedef logic [`CACHE_TAG_BITS-1:0]     tag_t;
  typedef logic [`CACHE_BR_ADDR_BITS-1:0] br_addr_t;

  // whole line, column c sits at bits [32*c +: 32]
  typedef logic [(32 << `CACHE_COL_IX_BITS)-1:0] line_t;

  typedef enum logic [2:0] {
    IDLE,
    EVICT,
    FILL_CMD,
    FILL_WAIT,
    FILL_BEAT,
    TAG_UPDATE
  } burst_state_t;

endpackage

/* hw/cache_ifs.sv */
////////////////////////////////////////////////////////////////////////////
// data cache internal interfaces
// store_if is the line store port, refill_if links lookup and burst FSM
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cache_cfg.svh"

interface store_if
  import cache_pkg::*;
();

  line_ix_t line_ix;
  // one set of byte enables per column
  byte_en_t [(1 << `CACHE_COL_IX_BITS)-1:0] col_we;
  line_t    wr_line;
  logic     tag_we;
  tag_t     tag_wr;
  logic     dirty_wr;
  logic     valid_wr;

  // combinational read of the indexed entry
  line_t    rd_line;
  tag_t     rd_tag;
  logic     rd_valid;
  logic     rd_dirty;

  modport lookup (
    output line_ix, col_we, wr_line, tag_we, tag_wr, dirty_wr, valid_wr,
    input  rd_line, rd_tag, rd_valid, rd_dirty
  );

  modport store (
    input  line_ix, col_we, wr_line, tag_we, tag_wr, dirty_wr, valid_wr,
    output rd_line, rd_tag, rd_valid, rd_dirty
  );

endinterface

interface refill_if
  import cache_pkg::*;
();

  logic     miss;
  logic     victim_dirty;
  br_addr_t victim_addr;
  br_addr_t fill_addr;
  line_t    victim_line;

  logic     fill_active;
  logic     fill_we;
  beat_ix_t fill_beat;
  beat_t    fill_data;
  logic     tag_we;

  modport lookup (
    output miss, victim_dirty, victim_addr, fill_addr, victim_line,
    input  fill_active, fill_we, fill_beat, fill_data, tag_we
  );

  modport ctrl (
    input  miss, victim_dirty, victim_addr, fill_addr, victim_line,
    output fill_active, fill_we, fill_beat, fill_data, tag_we
  );

endinterface

/* hw/line_store.sv */
////////////////////////////////////////////////////////////////////////////
// cache line store
// tag, valid and dirty per line plus byte-writable line data
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cache_cfg.svh"

module line_store
  import cache_pkg::*;
(
  input logic    clk,
  input logic    rst,
  store_if.store sp
);

  localparam int LINES = 1 << `CACHE_LINE_IX_BITS;
  localparam int COLS  = 1 << `CACHE_COL_IX_BITS;

  line_t            lines [LINES];
  tag_t             tags  [LINES];
  logic             dirty [LINES];
  logic [LINES-1:0] valid;

  // read port follows line_ix with no register
  assign sp.rd_line  = lines[sp.line_ix];
  assign sp.rd_tag   = tags[sp.line_ix];
  assign sp.rd_dirty = dirty[sp.line_ix];
  assign sp.rd_valid = valid[sp.line_ix];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (sp.tag_we) begin
      valid[sp.line_ix] <= sp.valid_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (sp.tag_we) begin
      tags[sp.line_ix]  <= sp.tag_wr;
      dirty[sp.line_ix] <= sp.dirty_wr;
    end
  end

  // byte lanes of every column are written independently
  always_ff @(posedge clk) begin
    for (int c = 0; c < COLS; c++) begin
      for (int b = 0; b < 4; b++) begin
        if (sp.col_we[c][b]) begin
          lines[sp.line_ix][32*c + 8*b +: 8] <= sp.wr_line[32*c + 8*b +: 8];
        end
      end
    end
  end

endmodule

/* hw/cache_lookup.sv */
////////////////////////////////////////////////////////////////////////////
// cache lookup
// address split, hit test, host read/write steering and fill write merge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_lookup
  import cache_pkg::*;
(
  input  word_t      address,
  input  word_t      data_in,
  input  byte_en_t   write_enable,
  output word_t      data_out,
  output logic       data_out_ready,
  output logic       busy,
  store_if.lookup    sp,
  refill_if.lookup   rf
);

  // |tag|line|col|00|
  localparam int COL_LSB = 2;
  localparam int IX_LSB  = COL_LSB + `CACHE_COL_IX_BITS;
  localparam int TAG_LSB = IX_LSB + `CACHE_LINE_IX_BITS;

  localparam int COLS          = 1 << `CACHE_COL_IX_BITS;
  localparam int BEATS         = `CACHE_BEATS_PER_LINE;
  localparam int COLS_PER_BEAT = COLS / BEATS;

  col_ix_t  req_col;
  line_ix_t req_ix;
  tag_t     req_tag;
  logic     hit;
  logic     host_wr;

  assign req_col = address[COL_LSB +: `CACHE_COL_IX_BITS];
  assign req_ix  = address[IX_LSB +: `CACHE_LINE_IX_BITS];
  assign req_tag = address[TAG_LSB +: `CACHE_TAG_BITS];

  assign hit     = sp.rd_valid && (sp.rd_tag == req_tag);
  assign host_wr = |write_enable;

  assign busy           = !hit;
  assign data_out       = sp.rd_line[req_col*$bits(word_t) +: $bits(word_t)];
  assign data_out_ready = hit && !host_wr;

  // the burst FSM only sees the miss and the victim state
  assign rf.miss         = !hit;
  assign rf.victim_dirty = sp.rd_valid && sp.rd_dirty;
  assign rf.victim_addr  = {sp.rd_tag, req_ix, beat_ix_t'(0)};
  assign rf.fill_addr    = {req_tag, req_ix, beat_ix_t'(0)};
  assign rf.victim_line  = sp.rd_line;

  // tag writes always install the requested tag as valid
  // a fill leaves it clean, a host write marks it dirty
  assign sp.line_ix  = req_ix;
  assign sp.tag_wr   = req_tag;
  assign sp.valid_wr = 1'b1;
  assign sp.dirty_wr = !rf.fill_active;

  always_comb begin
    sp.col_we = '0;
    if (rf.fill_active) begin
      // beat replicated over the line, enables pick its two columns
      sp.wr_line = {BEATS{rf.fill_data}};
      sp.tag_we  = rf.tag_we;
      if (rf.fill_we) begin
        for (int k = 0; k < COLS_PER_BEAT; k++) begin
          sp.col_we[COLS_PER_BEAT*rf.fill_beat + k] = '1;
        end
      end
    end else begin
      sp.wr_line = {COLS{data_in}};
      sp.tag_we  = hit && host_wr;
      if (hit) begin
        sp.col_we[req_col] = write_enable;
      end
    end
  end

endmodule

/* hw/burst_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// burst controller
// writes back dirty victims and fills missed lines over the burst RAM
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cache_cfg.svh"

module burst_ctrl
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  refill_if.ctrl   rf,
  output logic     br_cmd,
  output logic     br_cmd_en,
  output br_addr_t br_addr,
  output beat_t    br_wr_data,
  input  beat_t    br_rd_data,
  input  logic     br_rd_data_valid
);

  localparam beat_ix_t LAST_BEAT = beat_ix_t'(`CACHE_BEATS_PER_LINE - 1);

  burst_state_t state;
  beat_ix_t     beat;
  logic         start_evict;
  logic         start_fill;
  logic         in_fill;

  assign start_evict = (state == IDLE) && rf.miss && rf.victim_dirty;
  // a fill starts straight from a clean miss or after the last victim beat
  assign start_fill  = ((state == IDLE) && rf.miss && !rf.victim_dirty) ||
                       ((state == EVICT) && (beat == '0));
  assign in_fill     = (state == FILL_WAIT) || (state == FILL_BEAT);

  // read beats go to the store in the cycle they arrive
  assign rf.fill_active = (state != IDLE);
  assign rf.fill_we     = in_fill && br_rd_data_valid;
  assign rf.fill_beat   = beat;
  assign rf.fill_data   = br_rd_data;
  assign rf.tag_we      = (state == TAG_UPDATE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      beat      <= '0;
      br_cmd_en <= 1'b0;
    end else begin
      br_cmd_en <= start_evict || start_fill;
      case (state)
        IDLE: begin
          if (start_evict) begin
            beat  <= beat + 1'b1;
            state <= EVICT;
          end else if (start_fill) begin
            state <= FILL_CMD;
          end
        end
        EVICT: begin
          // beat wraps to zero once the last victim beat is on the bus
          if (beat == '0) begin
            state <= FILL_CMD;
          end else begin
            beat <= beat + 1'b1;
          end
        end
        FILL_CMD: begin
          state <= FILL_WAIT;
        end
        FILL_WAIT: begin
          if (br_rd_data_valid) begin
            beat  <= beat + 1'b1;
            state <= FILL_BEAT;
          end
        end
        FILL_BEAT: begin
          if (br_rd_data_valid) begin
            beat <= beat + 1'b1;
            if (beat == LAST_BEAT) begin
              state <= TAG_UPDATE;
            end
          end
        end
        TAG_UPDATE: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // command, address and write beats toward the RAM
  always_ff @(posedge clk) begin
    if (start_evict || start_fill) begin
      br_cmd  <= start_evict;
      br_addr <= start_evict ? rf.victim_addr : rf.fill_addr;
    end
    if (start_evict || (state == EVICT)) begin
      br_wr_data <= rf.victim_line[beat*$bits(beat_t) +: $bits(beat_t)];
    end
  end

endmodule

/* hw/cache_top.sv */
////////////////////////////////////////////////////////////////////////////
// data cache top level
// direct-mapped write-back cache in front of a 64-bit burst RAM
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module cache_top
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // host side
  input  word_t    address,
  input  word_t    data_in,
  input  byte_en_t write_enable,
  output word_t    data_out,
  output logic     data_out_ready,
  output logic     busy,

  // burst RAM side
  output logic     br_cmd,
  output logic     br_cmd_en,
  output br_addr_t br_addr,
  output beat_t    br_wr_data,
  input  beat_t    br_rd_data,
  input  logic     br_rd_data_valid
);

  store_if  store_bus ();
  refill_if refill_bus ();

  line_store u_store (
    .clk (clk),
    .rst (rst),
    .sp  (store_bus.store)
  );

  cache_lookup u_lookup (
    .address        (address),
    .data_in        (data_in),
    .write_enable   (write_enable),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy),
    .sp             (store_bus.lookup),
    .rf             (refill_bus.lookup)
  );

  burst_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .rf               (refill_bus.ctrl),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

endmodule

/* bench/burst_ram_model.sv */
////////////////////////////////////////////////////////////////////////////
// behavioral burst RAM for the cache testbench
// four-beat bursts, fixed read delay, command counters per type
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cache_cfg.svh"

module burst_ram_model
  import cache_pkg::*;
#(
  parameter int READ_DELAY = 3
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     br_cmd,
  input  logic     br_cmd_en,
  input  br_addr_t br_addr,
  input  beat_t    br_wr_data,
  output beat_t    br_rd_data,
  output logic     br_rd_data_valid
);

  localparam int DEPTH = 1 << `CACHE_BR_ADDR_BITS;
  localparam int BEATS = `CACHE_BEATS_PER_LINE;

  beat_t    mem [DEPTH];
  int       rd_bursts;
  int       wr_bursts;
  br_addr_t wr_ptr;
  br_addr_t rd_ptr;
  int       wr_left;
  int       rd_left;
  int       rd_wait;
  beat_t    rd_data_q = '0;
  logic     rd_valid_q = 1'b0;

  assign br_rd_data       = rd_data_q;
  assign br_rd_data_valid = rd_valid_q;

  always @(posedge clk) begin
    if (rst) begin
      rd_bursts  <= 0;
      wr_bursts  <= 0;
      wr_left    <= 0;
      rd_left    <= 0;
      rd_wait    <= 0;
      rd_valid_q <= 1'b0;
      rd_data_q  <= '0;
    end else begin
      rd_valid_q <= 1'b0;
      // beats 1..3 of a write follow the command back to back
      if (wr_left != 0) begin
        mem[wr_ptr] <= br_wr_data;
        wr_ptr      <= wr_ptr + 1'b1;
        wr_left     <= wr_left - 1;
      end
      if (rd_left != 0) begin
        if (rd_wait != 0) begin
          rd_wait <= rd_wait - 1;
        end else begin
          rd_data_q  <= mem[rd_ptr];
          rd_valid_q <= 1'b1;
          rd_ptr     <= rd_ptr + 1'b1;
          rd_left    <= rd_left - 1;
        end
      end
      if (br_cmd_en) begin
        if (br_cmd) begin
          wr_bursts   <= wr_bursts + 1;
          mem[br_addr] <= br_wr_data;
          wr_ptr      <= br_addr + 1'b1;
          wr_left     <= BEATS - 1;
        end else begin
          // READ_DELAY quiet cycles between the command and beat 0
          rd_bursts <= rd_bursts + 1;
          rd_ptr    <= br_addr;
          rd_wait   <= READ_DELAY - 1;
          rd_left   <= BEATS;
        end
      end
    end
  end

endmodule

/* bench/cache_props.sv */
////////////////////////////////////////////////////////////////////////////
// cache protocol assertions
// burst command spacing and host busy against burst activity
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module cache_props (
  input logic clk,
  input logic rst,
  input logic busy,
  input logic br_cmd_en,
  input logic br_rd_data_valid
);

  // a command is always a single-cycle pulse
  cmd_single_pulse: assert property (
    @(posedge clk) disable iff (rst) br_cmd_en |=> !br_cmd_en
  ) else $error("br_cmd_en high on two consecutive cycles");

  // a hit is only reported while the burst side is quiet
  hit_when_quiet: assert property (
    @(posedge clk) disable iff (rst) !busy |-> !br_cmd_en && !br_rd_data_valid
  ) else $error("busy low during a burst command or read data");

  // no new command while a read burst is still returning
  cmd_outside_read: assert property (
    @(posedge clk) disable iff (rst) br_cmd_en |-> !br_rd_data_valid
  ) else $error("br_cmd_en raised during read data");

endmodule

/* bench/cache_tb.sv */
////////////////////////////////////////////////////////////////////////////
// data cache testbench
// table of host reads and writes checked against a shadow byte memory
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_tb
  import cache_pkg::*;
();

  localparam int MEM_BYTES    = 1 << (`CACHE_BR_ADDR_BITS + 3);
  localparam int LINE_BYTES   = 4 << `CACHE_COL_IX_BITS;
  localparam int IX_LSB       = 2 + `CACHE_COL_IX_BITS;
  localparam int TAG_LSB      = IX_LSB + `CACHE_LINE_IX_BITS;
  localparam int RESET_CYCLES = 5;

  typedef struct packed {
    logic       wr;
    word_t      addr;
    word_t      data;
    byte_en_t   be;
    logic [3:0] exp_rd;
    logic [3:0] exp_wr;
    word_t      victim;
  } row_t;

  logic     clk;
  logic     rst;
  word_t    address;
  word_t    data_in;
  byte_en_t write_enable;
  word_t    data_out;
  logic     data_out_ready;
  logic     busy;
  logic     br_cmd;
  logic     br_cmd_en;
  br_addr_t br_addr;
  beat_t    br_wr_data;
  beat_t    br_rd_data;
  logic     br_rd_data_valid;

  row_t       rows [$];
  logic [7:0] shadow [MEM_BYTES];
  int         seed;
  int         cycle_count;
  int         cycle_limit;

  cache_top dut (
    .clk              (clk),
    .rst              (rst),
    .address          (address),
    .data_in          (data_in),
    .write_enable     (write_enable),
    .data_out         (data_out),
    .data_out_ready   (data_out_ready),
    .busy             (busy),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  burst_ram_model #(.READ_DELAY(3)) ram (
    .clk              (clk),
    .rst              (rst),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  bind cache_top cache_props props (
    .clk              (clk),
    .rst              (rst),
    .busy             (busy),
    .br_cmd_en        (br_cmd_en),
    .br_rd_data_valid (br_rd_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // byte address of a word from tag, line index and column
  function automatic word_t line_addr(input int tag, input int ix, input int col);
    return word_t'((tag << TAG_LSB) | (ix << IX_LSB) | (col << 2));
  endfunction

  function automatic word_t shadow_word(input word_t a);
    int base;
    base = int'(a);
    return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
  endfunction

  task automatic add_row(input logic wr, input word_t addr, input word_t data,
                         input byte_en_t be, input int exp_rd, input int exp_wr,
                         input word_t victim);
    row_t r;
    r.wr     = wr;
    r.addr   = addr;
    r.data   = data;
    r.be     = be;
    r.exp_rd = 4'(exp_rd);
    r.exp_wr = 4'(exp_wr);
    r.victim = victim;
    rows.push_back(r);
  endtask

  // op, address, data, byte enables, new read bursts, new write bursts, victim
  task automatic build_table();
    add_row(1'b0, line_addr(1, 2, 0), '0, '0, 1, 0, '0);
    add_row(1'b0, line_addr(1, 2, 5), '0, '0, 0, 0, '0);
    add_row(1'b0, line_addr(1, 2, 7), '0, '0, 0, 0, '0);
    add_row(1'b1, line_addr(1, 2, 3), 32'ha5a5_1234, 4'b0101, 0, 0, '0);
    add_row(1'b1, line_addr(1, 2, 6), 32'hdead_beef, 4'b1100, 0, 0, '0);
    add_row(1'b0, line_addr(1, 2, 3), '0, '0, 0, 0, '0);
    add_row(1'b0, line_addr(1, 2, 6), '0, '0, 0, 0, '0);
    add_row(1'b0, line_addr(3, 2, 1), '0, '0, 1, 1, line_addr(1, 2, 0));
    add_row(1'b0, line_addr(1, 2, 3), '0, '0, 1, 0, '0);
    add_row(1'b0, line_addr(2, 7, 0), '0, '0, 1, 0, '0);
    add_row(1'b1, line_addr(5, 7, 4), 32'h1357_9bdf, 4'b0110, 1, 0, '0);
    add_row(1'b0, line_addr(5, 7, 4), '0, '0, 0, 0, '0);
    add_row(1'b1, line_addr(5, 7, 5), 32'h0bad_f00d, 4'b1001, 0, 0, '0);
    add_row(1'b0, line_addr(6, 7, 0), '0, '0, 1, 1, line_addr(5, 7, 0));
    add_row(1'b0, line_addr(2, 7, 2), '0, '0, 1, 0, '0);
    add_row(1'b0, line_addr(0, 0, 0), '0, '0, 1, 0, '0);
    add_row(1'b0, line_addr(15, 15, 7), '0, '0, 1, 0, '0);
    add_row(1'b1, line_addr(15, 15, 0), 32'h0000_00c3, 4'b0001, 0, 0, '0);
    add_row(1'b0, line_addr(0, 15, 0), '0, '0, 1, 1, line_addr(15, 15, 0));
  endtask

  // random RAM image, mirrored byte by byte, little endian within a beat
  task automatic fill_memory();
    beat_t beat;
    for (int w = 0; w < (1 << `CACHE_BR_ADDR_BITS); w++) begin
      beat = {$random(seed), $random(seed)};
      ram.mem[w] = beat;
      for (int b = 0; b < 8; b++) begin
        shadow[8*w + b] = beat[8*b +: 8];
      end
    end
  endtask

  task automatic wait_not_busy();
    do begin
      @(negedge clk);
    end while (busy);
  endtask

  task automatic check_line(input word_t victim);
    int    base;
    beat_t exp_beat;
    base = (int'(victim) / LINE_BYTES) * LINE_BYTES;
    for (int k = 0; k < `CACHE_BEATS_PER_LINE; k++) begin
      for (int b = 0; b < 8; b++) begin
        exp_beat[8*b +: 8] = shadow[base + 8*k + b];
      end
      check_equal(ram.mem[base/8 + k], exp_beat,
                  $sformatf("RAM beat %0d of line at %0h after write-back", k, base));
    end
  endtask

  task automatic run_row(input int i);
    row_t r;
    int   rd_start;
    int   wr_start;
    r        = rows[i];
    rd_start = ram.rd_bursts;
    wr_start = ram.wr_bursts;
    address      = r.addr;
    data_in      = r.data;
    write_enable = r.wr ? r.be : 4'b0000;
    wait_not_busy();
    if (r.wr) begin
      check_equal(data_out_ready, 1'b0, $sformatf("row %0d data_out_ready on write", i));
      for (int b = 0; b < 4; b++) begin
        if (r.be[b]) begin
          shadow[int'(r.addr) + b] = r.data[8*b +: 8];
        end
      end
    end else begin
      check_equal(data_out_ready, 1'b1, $sformatf("row %0d data_out_ready on read", i));
      check_equal(data_out, shadow_word(r.addr), $sformatf("row %0d read data", i));
    end
    // a write hit commits at this edge
    @(posedge clk);
    #2;
    write_enable = 4'b0000;
    check_equal(ram.rd_bursts - rd_start, r.exp_rd, $sformatf("row %0d read bursts", i));
    check_equal(ram.wr_bursts - wr_start, r.exp_wr, $sformatf("row %0d write bursts", i));
    if (r.exp_wr != 0) begin
      check_line(r.victim);
    end
  endtask

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        $display("timeout: test did not finish within %0d clock cycles", cycle_limit);
        $display("Regression failed");
        $fatal(1, "timeout");
      end
    end
  end

  initial begin
    seed         = 20;
    rst          = 1'b1;
    address      = '0;
    data_in      = '0;
    write_enable = '0;
    build_table();
    cycle_limit = rows.size() * 40 + RESET_CYCLES;
    fill_memory();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
    check_equal(br_cmd_en, 1'b0, "br_cmd_en after reset");
    check_equal(busy, 1'b1, "busy after reset");
    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

/* files.f */
+incdir+hw
hw/cache_pkg.sv
hw/cache_ifs.sv
hw/line_store.sv
hw/cache_lookup.sv
hw/burst_ctrl.sv
hw/cache_top.sv
bench/burst_ram_model.sv
bench/cache_props.sv
bench/cache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 --top-module cache_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vcache_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
